// File: common/dispatchPkg.sv
/* Dispatch stage shared definitions */
`default_nettype none

package dispatchPkg;

	// default stage configuration, the top level may override each of these
	parameter int DISPATCH_WIDTH   = 4;
	parameter int NUM_SIMPLE_PIPES = 2;

	// default queue sizes
	parameter int SIZE_ISSUEQ     = 32;
	parameter int SIZE_ACTIVELIST = 64;
	// load queue and store queue share one size
	parameter int SIZE_LSQ        = 16;

	// field widths of the dispatch packets
	parameter int ISSUE_PIPE_W = 3;
	parameter int SEQ_W        = 8;
	parameter int CAUSE_W      = 4;
	parameter int AL_ID_W      = 6;
	parameter int LSQ_ID_W     = 4;

	// fixed pipes for memory, branch and complex instructions
	parameter logic [ISSUE_PIPE_W-1:0] MEM_PIPE     = 3'd0;
	parameter logic [ISSUE_PIPE_W-1:0] BRANCH_PIPE  = 3'd1;
	parameter logic [ISSUE_PIPE_W-1:0] COMPLEX_PIPE = 3'd2;
	// simple pipes are numbered upwards from here
	parameter logic [ISSUE_PIPE_W-1:0] FIRST_SIMPLE_PIPE = 3'd3;

	// functional unit class decoded by the front end
	typedef enum logic [1:0]
	{
		fuSimple  = 2'd0,
		fuComplex = 2'd1,
		fuBranch  = 2'd2,
		fuMem     = 2'd3
	} fuType;

endpackage

`default_nettype wire

// File: dispatch/capacityCheck.sv
/* Back-end room check */
`default_nettype none

module capacityCheck #(
	parameter int dispatchWidth = dispatchPkg::DISPATCH_WIDTH,
	parameter int iqSize        = dispatchPkg::SIZE_ISSUEQ,
	parameter int alSize        = dispatchPkg::SIZE_ACTIVELIST,
	parameter int lsqSize       = dispatchPkg::SIZE_LSQ
) (
	input  logic                     isLoad_i  [dispatchWidth],
	input  logic                     isStore_i [dispatchWidth],
	input  logic                     renameReady_i,
	input  logic                     iqflRamReady_i,
	input  logic [$clog2(iqSize):0]  issueQueueCnt_i,
	input  logic [$clog2(alSize):0]  activeListCnt_i,
	input  logic [$clog2(lsqSize):0] loadQueueCnt_i,
	input  logic [$clog2(lsqSize):0] storeQueueCnt_i,
	output logic                     stall_o,
	output logic                     groupAccept_o,
	output logic                     dispatchReady_o,
	output logic                     backEndFull_o
);

	// one extra bit so a group made only of loads still fits
	localparam int CNT_W = $clog2(dispatchWidth) + 1;

	logic [CNT_W-1:0] loadCnt;
	logic [CNT_W-1:0] storeCnt;
	logic             iqStall;
	logic             alStall;
	logic             loadStall;
	logic             storeStall;

	// lane valid is ignored here, rename clears the flags of empty lanes
	always_comb
	begin
		loadCnt  = '0;
		storeCnt = '0;
		for (int i = 0; i < dispatchWidth; i++)
		begin
			loadCnt  = loadCnt + CNT_W'(isLoad_i[i]);
			storeCnt = storeCnt + CNT_W'(isStore_i[i]);
		end
	end

	// the issue queue and active list always reserve a full group of entries
	assign iqStall    = ((int'(issueQueueCnt_i) + dispatchWidth) > iqSize) | ~iqflRamReady_i;
	assign alStall    = (int'(activeListCnt_i) + dispatchWidth) > alSize;
	// the load and store queues only need room for the flagged lanes
	assign loadStall  = (int'(loadQueueCnt_i) + int'(loadCnt)) > lsqSize;
	assign storeStall = (int'(storeQueueCnt_i) + int'(storeCnt)) > lsqSize;

	assign stall_o = iqStall | alStall | loadStall | storeStall;

	// ready goes to the queues, full goes back to rename and the fetch buffer
	assign groupAccept_o   = ~stall_o & renameReady_i;
	assign dispatchReady_o = groupAccept_o;
	assign backEndFull_o   = stall_o;

endmodule

`default_nettype wire

// File: dispatch/exePipeScheduler.sv
/* Issue pipe steering */
`default_nettype none

module exePipeScheduler #(
	parameter int dispatchWidth  = dispatchPkg::DISPATCH_WIDTH,
	parameter int numSimplePipes = dispatchPkg::NUM_SIMPLE_PIPES
) (
	input  logic                                 clk,
	input  logic                                 arstN_i,
	input  logic                                 recoverFlag_i,
	input  logic                                 groupAccept_i,
	input  dispatchPkg::fuType                   fu_i       [dispatchWidth],
	output logic [dispatchPkg::ISSUE_PIPE_W-1:0] exePipe_o  [dispatchWidth],
	output logic                                 isSimple_o [dispatchWidth]
);

	localparam int PIPE_W = dispatchPkg::ISSUE_PIPE_W;
	// a single simple pipe still gets a one-bit pointer that stays at zero
	localparam int PTR_W  = (numSimplePipes > 1) ? $clog2(numSimplePipes) : 1;

	// simple pipe that the first simple instruction of the group will use
	logic [PTR_W-1:0] rrPtr;
	logic [PTR_W-1:0] rrPtrNext;

	always_comb
	begin
		int simpleCnt;
		int simpleSlot;

		simpleCnt = 0;
		for (int i = 0; i < dispatchWidth; i++)
		begin
			isSimple_o[i] = 1'b0;
			// slot of this lane among the simple pipes, used only for simple lanes
			simpleSlot = (int'(rrPtr) + simpleCnt) % numSimplePipes;
			case (fu_i[i])
				dispatchPkg::fuMem:
				begin
					exePipe_o[i] = dispatchPkg::MEM_PIPE;
				end
				dispatchPkg::fuBranch:
				begin
					exePipe_o[i] = dispatchPkg::BRANCH_PIPE;
				end
				dispatchPkg::fuComplex:
				begin
					exePipe_o[i] = dispatchPkg::COMPLEX_PIPE;
				end
				default:
				begin
					// simple lanes take consecutive pipes in lane order
					exePipe_o[i]  = PIPE_W'(int'(dispatchPkg::FIRST_SIMPLE_PIPE) + simpleSlot);
					isSimple_o[i] = 1'b1;
					simpleCnt     = simpleCnt + 1;
				end
			endcase
		end
		// the next group continues where this one stopped
		rrPtrNext = PTR_W'((int'(rrPtr) + simpleCnt) % numSimplePipes);
	end

	// recovery wins over an accept in the same cycle
	always_ff @(posedge clk or negedge arstN_i)
	begin
		if (!arstN_i)
		begin
			rrPtr <= '0;
		end
		else if (recoverFlag_i)
		begin
			rrPtr <= '0;
		end
		else if (groupAccept_i)
		begin
			rrPtr <= rrPtrNext;
		end
	end

endmodule

`default_nettype wire

// File: dispatch/packetFormer.sv
/* Back-end lane packets */
`default_nettype none

module packetFormer #(
	parameter int dispatchWidth = dispatchPkg::DISPATCH_WIDTH
) (
	input  logic                                 stall_i,
	input  logic [dispatchPkg::SEQ_W-1:0]        seqNo_i          [dispatchWidth],
	input  logic                                 isLoad_i         [dispatchWidth],
	input  logic                                 isStore_i        [dispatchWidth],
	input  logic                                 exception_i      [dispatchWidth],
	input  logic [dispatchPkg::CAUSE_W-1:0]      exceptionCause_i [dispatchWidth],
	input  logic                                 valid_i          [dispatchWidth],
	input  logic [dispatchPkg::AL_ID_W-1:0]      alId_i           [dispatchWidth],
	input  logic [dispatchPkg::LSQ_ID_W-1:0]     lsqId_i          [dispatchWidth],
	input  logic [dispatchPkg::ISSUE_PIPE_W-1:0] exePipe_i        [dispatchWidth],
	input  logic                                 isSimple_i       [dispatchWidth],
	output logic [dispatchPkg::SEQ_W-1:0]        iqSeqNo_o        [dispatchWidth],
	output logic [dispatchPkg::ISSUE_PIPE_W-1:0] iqPipe_o         [dispatchWidth],
	output logic                                 iqIsSimple_o     [dispatchWidth],
	output logic [dispatchPkg::AL_ID_W-1:0]      iqAlId_o         [dispatchWidth],
	output logic [dispatchPkg::LSQ_ID_W-1:0]     iqLsqId_o        [dispatchWidth],
	output logic                                 iqValid_o        [dispatchWidth],
	output logic [dispatchPkg::SEQ_W-1:0]        alSeqNo_o        [dispatchWidth],
	output logic                                 alException_o    [dispatchWidth],
	output logic [dispatchPkg::CAUSE_W-1:0]      alCause_o        [dispatchWidth],
	output logic                                 alIsLoad_o       [dispatchWidth],
	output logic                                 alIsStore_o      [dispatchWidth],
	output logic                                 alValid_o        [dispatchWidth],
	output logic [dispatchPkg::SEQ_W-1:0]        lsqSeqNo_o       [dispatchWidth],
	output logic                                 lsqIsLoad_o      [dispatchWidth],
	output logic                                 lsqIsStore_o     [dispatchWidth],
	output logic                                 lsqValid_o       [dispatchWidth]
);

	always_comb
	begin
		for (int i = 0; i < dispatchWidth; i++)
		begin
			// issue queue gets the steered pipe in place of the decoded unit type
			iqSeqNo_o[i]    = seqNo_i[i];
			iqPipe_o[i]     = exePipe_i[i];
			iqIsSimple_o[i] = isSimple_i[i];
			iqAlId_o[i]     = alId_i[i];
			iqLsqId_o[i]    = lsqId_i[i];
			// an excepting instruction never issues
			iqValid_o[i]    = valid_i[i] & ~stall_i & ~exception_i[i];

			alSeqNo_o[i]     = seqNo_i[i];
			alException_o[i] = exception_i[i];
			alCause_o[i]     = exceptionCause_i[i];
			alIsLoad_o[i]    = isLoad_i[i];
			alIsStore_o[i]   = isStore_i[i];
			// it still takes an active list entry so it can be flagged at retire
			alValid_o[i]     = valid_i[i] & ~stall_i;

			lsqSeqNo_o[i]   = seqNo_i[i];
			lsqIsLoad_o[i]  = isLoad_i[i];
			lsqIsStore_o[i] = isStore_i[i];
			// and it does not claim a load or store queue entry either
			lsqValid_o[i]   = valid_i[i] & ~stall_i & ~exception_i[i];
		end
	end

endmodule

`default_nettype wire

// File: dispatch/exceptionSelect.sv
/* Group exception select */
`default_nettype none

module exceptionSelect #(
	parameter int dispatchWidth = dispatchPkg::DISPATCH_WIDTH
) (
	input  logic                            stall_i,
	input  logic                            exception_i      [dispatchWidth],
	input  logic                            valid_i          [dispatchWidth],
	input  logic [dispatchPkg::SEQ_W-1:0]   seqNo_i          [dispatchWidth],
	input  logic [dispatchPkg::CAUSE_W-1:0] exceptionCause_i [dispatchWidth],
	input  logic [dispatchPkg::AL_ID_W-1:0] alId_i           [dispatchWidth],
	output logic [dispatchPkg::SEQ_W-1:0]   excSeqNo_o,
	output logic [dispatchPkg::AL_ID_W-1:0] excAlId_o,
	output logic [dispatchPkg::CAUSE_W-1:0] excCause_o,
	output logic                            excValid_o
);

	localparam int ID_W = (dispatchWidth > 1) ? $clog2(dispatchWidth) : 1;

	// lanes holding a real instruction that raised an exception
	logic [dispatchWidth-1:0] excVec;
	// oldest excepting lane, lane 0 when none excepts
	logic [ID_W-1:0]          excId;

	always_comb
	begin
		excId = '0;
		// scan from the youngest lane down so the oldest hit is written last
		for (int i = dispatchWidth - 1; i >= 0; i--)
		begin
			excVec[i] = exception_i[i] & valid_i[i];
			if (excVec[i])
			begin
				excId = ID_W'(i);
			end
		end
	end

	assign excSeqNo_o = seqNo_i[excId];
	assign excAlId_o  = alId_i[excId];
	assign excCause_o = exceptionCause_i[excId];
	// held back on a stall, since the active list entry is not written then
	assign excValid_o = (|excVec) & ~stall_i;

endmodule

`default_nettype wire

// File: dispatch/dispatchTop.sv
/* Dispatch stage top level */
`default_nettype none

module dispatchTop #(
	parameter int dispatchWidth  = dispatchPkg::DISPATCH_WIDTH,
	parameter int numSimplePipes = dispatchPkg::NUM_SIMPLE_PIPES,
	parameter int iqSize         = dispatchPkg::SIZE_ISSUEQ,
	parameter int alSize         = dispatchPkg::SIZE_ACTIVELIST,
	parameter int lsqSize        = dispatchPkg::SIZE_LSQ
) (
	input  logic                                 clk,
	input  logic                                 arstN_i,

	// rename has a group ready for dispatch
	input  logic                                 renameReady_i,
	input  logic                                 iqflRamReady_i,
	input  logic                                 recoverFlag_i,

	// renamed group, one entry per dispatch lane
	input  logic [dispatchPkg::SEQ_W-1:0]        seqNo_i          [dispatchWidth],
	input  dispatchPkg::fuType                   fu_i             [dispatchWidth],
	input  logic                                 isLoad_i         [dispatchWidth],
	input  logic                                 isStore_i        [dispatchWidth],
	input  logic                                 exception_i      [dispatchWidth],
	input  logic [dispatchPkg::CAUSE_W-1:0]      exceptionCause_i [dispatchWidth],
	input  logic                                 valid_i          [dispatchWidth],
	input  logic [dispatchPkg::AL_ID_W-1:0]      alId_i           [dispatchWidth],
	input  logic [dispatchPkg::LSQ_ID_W-1:0]     lsqId_i          [dispatchWidth],

	// current occupancy of the back-end queues
	input  logic [$clog2(iqSize):0]              issueQueueCnt_i,
	input  logic [$clog2(alSize):0]              activeListCnt_i,
	input  logic [$clog2(lsqSize):0]             loadQueueCnt_i,
	input  logic [$clog2(lsqSize):0]             storeQueueCnt_i,

	// issue queue lanes
	output logic [dispatchPkg::SEQ_W-1:0]        iqSeqNo_o        [dispatchWidth],
	output logic [dispatchPkg::ISSUE_PIPE_W-1:0] iqPipe_o         [dispatchWidth],
	output logic                                 iqIsSimple_o     [dispatchWidth],
	output logic [dispatchPkg::AL_ID_W-1:0]      iqAlId_o         [dispatchWidth],
	output logic [dispatchPkg::LSQ_ID_W-1:0]     iqLsqId_o        [dispatchWidth],
	output logic                                 iqValid_o        [dispatchWidth],

	// active list lanes
	output logic [dispatchPkg::SEQ_W-1:0]        alSeqNo_o        [dispatchWidth],
	output logic                                 alException_o    [dispatchWidth],
	output logic [dispatchPkg::CAUSE_W-1:0]      alCause_o        [dispatchWidth],
	output logic                                 alIsLoad_o       [dispatchWidth],
	output logic                                 alIsStore_o      [dispatchWidth],
	output logic                                 alValid_o        [dispatchWidth],

	// load-store queue lanes
	output logic [dispatchPkg::SEQ_W-1:0]        lsqSeqNo_o       [dispatchWidth],
	output logic                                 lsqIsLoad_o      [dispatchWidth],
	output logic                                 lsqIsStore_o     [dispatchWidth],
	output logic                                 lsqValid_o       [dispatchWidth],

	// first excepting instruction of the group
	output logic [dispatchPkg::SEQ_W-1:0]        excSeqNo_o,
	output logic [dispatchPkg::AL_ID_W-1:0]      excAlId_o,
	output logic [dispatchPkg::CAUSE_W-1:0]      excCause_o,
	output logic                                 excValid_o,

	output logic                                 dispatchReady_o,
	output logic                                 backEndFull_o
);

	// some back-end queue has no room for this group
	logic                                 stall;
	// group leaves dispatch this cycle
	logic                                 groupAccept;
	logic [dispatchPkg::ISSUE_PIPE_W-1:0] exePipe  [dispatchWidth];
	logic                                 isSimple [dispatchWidth];

	capacityCheck #(
		.dispatchWidth (dispatchWidth),
		.iqSize        (iqSize),
		.alSize        (alSize),
		.lsqSize       (lsqSize)
	) i_capacityCheck (
		.isLoad_i        (isLoad_i),
		.isStore_i       (isStore_i),
		.renameReady_i   (renameReady_i),
		.iqflRamReady_i  (iqflRamReady_i),
		.issueQueueCnt_i (issueQueueCnt_i),
		.activeListCnt_i (activeListCnt_i),
		.loadQueueCnt_i  (loadQueueCnt_i),
		.storeQueueCnt_i (storeQueueCnt_i),
		.stall_o         (stall),
		.groupAccept_o   (groupAccept),
		.dispatchReady_o (dispatchReady_o),
		.backEndFull_o   (backEndFull_o)
	);

	// the pipe pointer only moves on groupAccept, so a held group keeps its pipes
	exePipeScheduler #(
		.dispatchWidth  (dispatchWidth),
		.numSimplePipes (numSimplePipes)
	) i_exePipeScheduler (
		.clk           (clk),
		.arstN_i       (arstN_i),
		.recoverFlag_i (recoverFlag_i),
		.groupAccept_i (groupAccept),
		.fu_i          (fu_i),
		.exePipe_o     (exePipe),
		.isSimple_o    (isSimple)
	);

	packetFormer #(
		.dispatchWidth (dispatchWidth)
	) i_packetFormer (
		.stall_i          (stall),
		.seqNo_i          (seqNo_i),
		.isLoad_i         (isLoad_i),
		.isStore_i        (isStore_i),
		.exception_i      (exception_i),
		.exceptionCause_i (exceptionCause_i),
		.valid_i          (valid_i),
		.alId_i           (alId_i),
		.lsqId_i          (lsqId_i),
		.exePipe_i        (exePipe),
		.isSimple_i       (isSimple),
		.iqSeqNo_o        (iqSeqNo_o),
		.iqPipe_o         (iqPipe_o),
		.iqIsSimple_o     (iqIsSimple_o),
		.iqAlId_o         (iqAlId_o),
		.iqLsqId_o        (iqLsqId_o),
		.iqValid_o        (iqValid_o),
		.alSeqNo_o        (alSeqNo_o),
		.alException_o    (alException_o),
		.alCause_o        (alCause_o),
		.alIsLoad_o       (alIsLoad_o),
		.alIsStore_o      (alIsStore_o),
		.alValid_o        (alValid_o),
		.lsqSeqNo_o       (lsqSeqNo_o),
		.lsqIsLoad_o      (lsqIsLoad_o),
		.lsqIsStore_o     (lsqIsStore_o),
		.lsqValid_o       (lsqValid_o)
	);

	exceptionSelect #(
		.dispatchWidth (dispatchWidth)
	) i_exceptionSelect (
		.stall_i          (stall),
		.exception_i      (exception_i),
		.valid_i          (valid_i),
		.seqNo_i          (seqNo_i),
		.exceptionCause_i (exceptionCause_i),
		.alId_i           (alId_i),
		.excSeqNo_o       (excSeqNo_o),
		.excAlId_o        (excAlId_o),
		.excCause_o       (excCause_o),
		.excValid_o       (excValid_o)
	);

endmodule

`default_nettype wire

// File: tests/dispatchCheck_assert.sv
/* Dispatch stage assertions */
`default_nettype none

module dispatchCheck #(
	parameter int dispatchWidth = dispatchPkg::DISPATCH_WIDTH
) (
	input logic clk,
	input logic arstN_i,
	input logic dispatchReady_i,
	input logic backEndFull_i,
	input logic excValid_i,
	input logic iqValid_i   [dispatchWidth],
	input logic alValid_i   [dispatchWidth],
	input logic lsqValid_i  [dispatchWidth],
	input logic valid_i     [dispatchWidth],
	input logic exception_i [dispatchWidth]
);

	// some lane heads into a back-end queue
	logic anyPacketValid;
	// some real instruction of the group raised an exception
	logic anyLaneExcepts;

	always_comb
	begin
		anyPacketValid = 1'b0;
		anyLaneExcepts = 1'b0;
		for (int i = 0; i < dispatchWidth; i++)
		begin
			anyPacketValid = anyPacketValid | iqValid_i[i] | alValid_i[i] | lsqValid_i[i];
			anyLaneExcepts = anyLaneExcepts | (valid_i[i] & exception_i[i]);
		end
	end

	readyNotFull: assert property (@(posedge clk) disable iff (!arstN_i)
		!(dispatchReady_i && backEndFull_i))
		else $error("dispatch ready and back-end full are high together");

	fullBlocksPackets: assert property (@(posedge clk) disable iff (!arstN_i)
		backEndFull_i |-> !anyPacketValid)
		else $error("a lane packet is valid while the back end is full");

	excNeedsLane: assert property (@(posedge clk) disable iff (!arstN_i)
		excValid_i |-> anyLaneExcepts)
		else $error("exception packet valid with no valid excepting lane");

endmodule

bind dispatchTop dispatchCheck #(
	.dispatchWidth (dispatchWidth)
) i_dispatchCheck (
	.clk             (clk),
	.arstN_i         (arstN_i),
	.dispatchReady_i (dispatchReady_o),
	.backEndFull_i   (backEndFull_o),
	.excValid_i      (excValid_o),
	.iqValid_i       (iqValid_o),
	.alValid_i       (alValid_o),
	.lsqValid_i      (lsqValid_o),
	.valid_i         (valid_i),
	.exception_i     (exception_i)
);

`default_nettype wire

// File: tests/dispatchTb.sv
/* Dispatch stage testbench */
`default_nettype none

module dispatchTb;

	localparam int DW         = dispatchPkg::DISPATCH_WIDTH;
	localparam int NSP        = dispatchPkg::NUM_SIMPLE_PIPES;
	localparam int IQ_SIZE    = dispatchPkg::SIZE_ISSUEQ;
	localparam int AL_SIZE    = dispatchPkg::SIZE_ACTIVELIST;
	localparam int LSQ_SIZE   = dispatchPkg::SIZE_LSQ;
	localparam int IQ_CNT_W   = $clog2(IQ_SIZE) + 1;
	localparam int AL_CNT_W   = $clog2(AL_SIZE) + 1;
	localparam int LSQ_CNT_W  = $clog2(LSQ_SIZE) + 1;
	localparam int PERIOD     = 20;
	localparam int RESET_CYCS = 8;
	localparam int NUM_GROUPS = 2000;

	// names follow the DUT ports so the instance connects by name
	logic                                 clk;
	logic                                 arstN_i;
	logic                                 renameReady_i;
	logic                                 iqflRamReady_i;
	logic                                 recoverFlag_i;
	logic [dispatchPkg::SEQ_W-1:0]        seqNo_i          [DW];
	dispatchPkg::fuType                   fu_i             [DW];
	logic                                 isLoad_i         [DW];
	logic                                 isStore_i        [DW];
	logic                                 exception_i      [DW];
	logic [dispatchPkg::CAUSE_W-1:0]      exceptionCause_i [DW];
	logic                                 valid_i          [DW];
	logic [dispatchPkg::AL_ID_W-1:0]      alId_i           [DW];
	logic [dispatchPkg::LSQ_ID_W-1:0]     lsqId_i          [DW];
	logic [IQ_CNT_W-1:0]                  issueQueueCnt_i;
	logic [AL_CNT_W-1:0]                  activeListCnt_i;
	logic [LSQ_CNT_W-1:0]                 loadQueueCnt_i;
	logic [LSQ_CNT_W-1:0]                 storeQueueCnt_i;
	logic [dispatchPkg::SEQ_W-1:0]        iqSeqNo_o        [DW];
	logic [dispatchPkg::ISSUE_PIPE_W-1:0] iqPipe_o         [DW];
	logic                                 iqIsSimple_o     [DW];
	logic [dispatchPkg::AL_ID_W-1:0]      iqAlId_o         [DW];
	logic [dispatchPkg::LSQ_ID_W-1:0]     iqLsqId_o        [DW];
	logic                                 iqValid_o        [DW];
	logic [dispatchPkg::SEQ_W-1:0]        alSeqNo_o        [DW];
	logic                                 alException_o    [DW];
	logic [dispatchPkg::CAUSE_W-1:0]      alCause_o        [DW];
	logic                                 alIsLoad_o       [DW];
	logic                                 alIsStore_o      [DW];
	logic                                 alValid_o        [DW];
	logic [dispatchPkg::SEQ_W-1:0]        lsqSeqNo_o       [DW];
	logic                                 lsqIsLoad_o      [DW];
	logic                                 lsqIsStore_o     [DW];
	logic                                 lsqValid_o       [DW];
	logic [dispatchPkg::SEQ_W-1:0]        excSeqNo_o;
	logic [dispatchPkg::AL_ID_W-1:0]      excAlId_o;
	logic [dispatchPkg::CAUSE_W-1:0]      excCause_o;
	logic                                 excValid_o;
	logic                                 dispatchReady_o;
	logic                                 backEndFull_o;

	// stimulus generator state, and the model's copy of the round-robin pointer
	logic [15:0] lfsr;
	int          modelPtr;

	dispatchTop #(
		.dispatchWidth  (DW),
		.numSimplePipes (NSP),
		.iqSize         (IQ_SIZE),
		.alSize         (AL_SIZE),
		.lsqSize        (LSQ_SIZE)
	) i_dispatchTop (.*);

	initial
	begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// x^16 + x^14 + x^13 + x^11 + 1, one step per bit handed out
	function automatic logic [31:0] randBits(input int n);
		logic [31:0] bits;
		logic        fb;
		bits = '0;
		for (int b = 0; b < n; b++)
		begin
			fb   = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			bits = {bits[30:0], fb};
		end
		return bits;
	endfunction

	// half the time the count sits within a few entries of the last one that still fits
	function automatic int occupancy(input int lastFit);
		if (randBits(1) != 0)
		begin
			return lastFit - 3 + int'(randBits(3));
		end
		return int'(randBits(3));
	endfunction

	task automatic checkValue(input string what, input int lane, input logic [31:0] got,
		input logic [31:0] exp);
		assert (got == exp)
		else
		begin
			$display("Mismatch at time %0t: %s lane %0d is %0h, expected %0h",
				$time, what, lane, got, exp);
			$display("ERRORS FOUND");
			$fatal(1, "stopped at the first wrong value");
		end
	endtask

	task automatic driveGroup();
		logic [31:0] r;
		for (int i = 0; i < DW; i++)
		begin
			seqNo_i[i]          = 8'(randBits(8));
			fu_i[i]             = dispatchPkg::fuType'(2'(randBits(2)));
			// only memory instructions carry a load or a store flag
			r                   = randBits(1);
			isLoad_i[i]         = (fu_i[i] == dispatchPkg::fuMem) && r[0];
			isStore_i[i]        = (fu_i[i] == dispatchPkg::fuMem) && !r[0];
			exception_i[i]      = randBits(2) == 0;
			exceptionCause_i[i] = 4'(randBits(4));
			valid_i[i]          = randBits(3) != 0;
			alId_i[i]           = 6'(randBits(6));
			lsqId_i[i]          = 4'(randBits(4));
		end
		renameReady_i   = randBits(2) != 0;
		iqflRamReady_i  = randBits(3) != 0;
		recoverFlag_i   = randBits(4) == 0;
		issueQueueCnt_i = IQ_CNT_W'(occupancy(IQ_SIZE - DW));
		activeListCnt_i = AL_CNT_W'(occupancy(AL_SIZE - DW));
		// two memory lanes in a group is typical, so aim a little below the size
		loadQueueCnt_i  = LSQ_CNT_W'(occupancy(LSQ_SIZE - 2));
		storeQueueCnt_i = LSQ_CNT_W'(occupancy(LSQ_SIZE - 2));
	endtask

	// reference model of the whole stage, applied to the group on the inputs now
	task automatic checkGroup();
		int                                   loads;
		int                                   stores;
		int                                   simpleIdx;
		int                                   excLane;
		int                                   sel;
		logic                                 expStall;
		logic                                 expAccept;
		logic                                 expSimple;
		logic                                 expIssue;
		logic [dispatchPkg::ISSUE_PIPE_W-1:0] expPipe;
		loads     = 0;
		stores    = 0;
		simpleIdx = 0;
		excLane   = -1;
		// a low reset clears the pointer at once
		if (!arstN_i)
		begin
			modelPtr = 0;
		end
		for (int i = 0; i < DW; i++)
		begin
			if (isLoad_i[i])
			begin
				loads++;
			end
			if (isStore_i[i])
			begin
				stores++;
			end
		end
		expStall = (int'(issueQueueCnt_i) + DW > IQ_SIZE) || !iqflRamReady_i ||
			(int'(activeListCnt_i) + DW > AL_SIZE) ||
			(int'(loadQueueCnt_i) + loads > LSQ_SIZE) ||
			(int'(storeQueueCnt_i) + stores > LSQ_SIZE);
		expAccept = !expStall && renameReady_i;
		checkValue("backEndFull_o", 0, 32'(backEndFull_o), 32'(expStall));
		checkValue("dispatchReady_o", 0, 32'(dispatchReady_o), 32'(expAccept));

		for (int i = 0; i < DW; i++)
		begin
			expSimple = 1'b0;
			case (fu_i[i])
				dispatchPkg::fuMem:     expPipe = dispatchPkg::MEM_PIPE;
				dispatchPkg::fuBranch:  expPipe = dispatchPkg::BRANCH_PIPE;
				dispatchPkg::fuComplex: expPipe = dispatchPkg::COMPLEX_PIPE;
				default:
				begin
					expPipe   = 3'(int'(dispatchPkg::FIRST_SIMPLE_PIPE) + (modelPtr + simpleIdx) % NSP);
					expSimple = 1'b1;
					simpleIdx++;
				end
			endcase
			// excepting lanes stay out of the issue queue and the load-store queue
			expIssue = valid_i[i] && !expStall && !exception_i[i];
			checkValue("iqPipe_o", i, 32'(iqPipe_o[i]), 32'(expPipe));
			checkValue("iqIsSimple_o", i, 32'(iqIsSimple_o[i]), 32'(expSimple));
			checkValue("iqSeqNo_o", i, 32'(iqSeqNo_o[i]), 32'(seqNo_i[i]));
			checkValue("iqAlId_o", i, 32'(iqAlId_o[i]), 32'(alId_i[i]));
			checkValue("iqLsqId_o", i, 32'(iqLsqId_o[i]), 32'(lsqId_i[i]));
			checkValue("iqValid_o", i, 32'(iqValid_o[i]), 32'(expIssue));
			checkValue("alSeqNo_o", i, 32'(alSeqNo_o[i]), 32'(seqNo_i[i]));
			checkValue("alException_o", i, 32'(alException_o[i]), 32'(exception_i[i]));
			checkValue("alCause_o", i, 32'(alCause_o[i]), 32'(exceptionCause_i[i]));
			checkValue("alIsLoad_o", i, 32'(alIsLoad_o[i]), 32'(isLoad_i[i]));
			checkValue("alIsStore_o", i, 32'(alIsStore_o[i]), 32'(isStore_i[i]));
			checkValue("alValid_o", i, 32'(alValid_o[i]), 32'(valid_i[i] && !expStall));
			checkValue("lsqSeqNo_o", i, 32'(lsqSeqNo_o[i]), 32'(seqNo_i[i]));
			checkValue("lsqIsLoad_o", i, 32'(lsqIsLoad_o[i]), 32'(isLoad_i[i]));
			checkValue("lsqIsStore_o", i, 32'(lsqIsStore_o[i]), 32'(isStore_i[i]));
			checkValue("lsqValid_o", i, 32'(lsqValid_o[i]), 32'(expIssue));
			if (excLane < 0 && valid_i[i] && exception_i[i])
			begin
				excLane = i;
			end
		end

		// lane 0 fields are shown when nothing excepts
		sel = (excLane < 0) ? 0 : excLane;
		checkValue("excValid_o", sel, 32'(excValid_o), 32'(excLane >= 0 && !expStall));
		checkValue("excSeqNo_o", sel, 32'(excSeqNo_o), 32'(seqNo_i[sel]));
		checkValue("excAlId_o", sel, 32'(excAlId_o), 32'(alId_i[sel]));
		checkValue("excCause_o", sel, 32'(excCause_o), 32'(exceptionCause_i[sel]));

		// pointer after the coming rising edge
		if (!arstN_i || recoverFlag_i)
		begin
			modelPtr = 0;
		end
		else if (expAccept)
		begin
			modelPtr = (modelPtr + simpleIdx) % NSP;
		end
	endtask

	initial
	begin
		lfsr     = 16'd28;
		modelPtr = 0;
		arstN_i  = 1'b0;
		// first group is on the inputs from time zero
		driveGroup();
		repeat (RESET_CYCS) @(posedge clk);
		// the first pass releases reset together with a fresh checked group
		for (int g = 0; g < NUM_GROUPS; g++)
		begin
			@(negedge clk);
			// one short reset pulse halfway through clears the pointer again
			arstN_i = (g != NUM_GROUPS / 2);
			driveGroup();
			#1;
			checkGroup();
		end
		$display("NO ERRORS");
		$finish;
	end

	// the run needs reset plus one cycle per group
	initial
	begin
		#((RESET_CYCS + NUM_GROUPS + 50) * PERIOD);
		$display("Timeout: the run did not finish in the expected number of cycles");
		$display("ERRORS FOUND");
		$fatal(1, "watchdog expired");
	end

endmodule

`default_nettype wire

// File: tb.f
common/dispatchPkg.sv
dispatch/capacityCheck.sv
dispatch/exePipeScheduler.sv
dispatch/packetFormer.sv
dispatch/exceptionSelect.sv
dispatch/dispatchTop.sv
tests/dispatchCheck_assert.sv
tests/dispatchTb.sv

// File: Makefile
SRCS := $(shell cat tb.f)

.PHONY: run clean

run: obj_dir/VdispatchTb
	out=$$(./obj_dir/VdispatchTb); echo "$$out"; echo "$$out" | grep -qx "NO ERRORS"

obj_dir/VdispatchTb: tb.f $(SRCS)
	verilator --binary --timing --assert --top-module dispatchTb -f tb.f

clean:
	rm -rf obj_dir
